//--- src.f
hdl/fractal_pkg.sv
hdl/pixel_scan.sv
hdl/escape_core.sv
hdl/pixel_fifo.sv
hdl/stream_packer.sv
hdl/pixel_generator.sv
tb/pixel_generator_assertions.sv
tb/tb_pixel_generator.sv

//--- Bender.yml
package:
  name: pixel_generator

sources:
  - hdl/fractal_pkg.sv
  - hdl/pixel_scan.sv
  - hdl/escape_core.sv
  - hdl/pixel_fifo.sv
  - hdl/stream_packer.sv
  - hdl/pixel_generator.sv
  - target: test
    files:
      - tb/pixel_generator_assertions.sv
      - tb/tb_pixel_generator.sv

//--- tb/tb_pixel_generator.sv
// Testbench for the fractal pixel generator
// Models escape counts and the packed byte stream, checks every accepted word

`timescale 1ns/100ps

module tb_pixel_generator;

    import fractal_pkg::*;

    localparam int     PIXELS          = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int     WORDS_PER_FRAME = PIXELS * PIXEL_BITS / STREAM_WIDTH;
    localparam int     MAX_ITER_BOUND  = 40;   // largest max_iter used below
    localparam int     RUN_FRAMES      = 6;
    localparam longint WATCHDOG_NS     =
        longint'(RUN_FRAMES) * PIXELS * (MAX_ITER_BOUND + 2) * 4 * 2;

    typedef struct packed {
        logic [STREAM_WIDTH-1:0] data;
        logic                    last;
        logic                    user;
    } beat_t;

    logic         out_stream_aclk = 1'b0;
    logic         axi_resetn;
    fractal_cfg_t cfg;
    logic [31:0]  tdata;
    logic [3:0]   tkeep;
    logic         tlast, tvalid, tuser, tready;

    fractal_cfg_t mandel_cfg, julia_cfg;
    beat_t        exp_q [$];
    beat_t        got_beat, want_beat;
    logic [15:0]  lfsr_q = 16'd44;
    logic         random_ready = 1'b0;
    int           ready_bits, reset_len, words_before_reset, saturated;
    int           checked_cnt = 0;    // words compared against the model
    int           seen_cnt = 0;       // every accepted word
    int           full_cycles = 0;
    int           seen_mark, full_mark;

    always #2 out_stream_aclk = ~out_stream_aclk;

    pixel_generator DUT (
        .out_stream_aclk     (out_stream_aclk),
        .axi_resetn          (axi_resetn),
        .cfg_i               (cfg),
        .out_stream_tdata_o  (tdata),
        .out_stream_tkeep_o  (tkeep),
        .out_stream_tlast_o  (tlast),
        .out_stream_tvalid_o (tvalid),
        .out_stream_tuser_o  (tuser),
        .out_stream_tready_i (tready)
    );

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        repeat (n) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    function automatic coord_t fix_mul(input coord_t a, input coord_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return coord_t'(p >>> FRACTIONAL_BITS);
    endfunction

    // Iterations completed before |z|^2 > 4 or max_iter
    function automatic iter_t escape_count(input coord_t px, input coord_t py,
                                           input fractal_cfg_t c);
        coord_t zx, zy, cx, cy, sq_x, sq_y, xy, mag;
        int     count;
        zx    = c.julia ? px : coord_t'(0);
        zy    = c.julia ? py : coord_t'(0);
        cx    = c.julia ? c.cx : px;
        cy    = c.julia ? c.cy : py;
        count = 0;
        while (count < int'(c.max_iter)) begin
            sq_x = fix_mul(zx, zx);
            sq_y = fix_mul(zy, zy);
            mag  = sq_x + sq_y;
            if (mag > ESCAPE_LIMIT) break;
            xy    = fix_mul(zx, zy);
            zx    = sq_x - sq_y + cx;
            zy    = xy + xy + cy;
            count = count + 1;
        end
        return iter_t'(count);
    endfunction

    // Expected words of one frame, bytes blue green red per pixel, little-endian
    task automatic push_frame(input fractal_cfg_t c, output int n_sat);
        logic [7:0] bytes [3*PIXELS];
        logic       word_last [WORDS_PER_FRAME];
        coord_t     px, py;
        iter_t      n;
        int         x, y, w, nb;
        n_sat = 0;
        nb    = 0;
        py    = c.start_y;
        for (w = 0; w < WORDS_PER_FRAME; w++) word_last[w] = 1'b0;
        for (y = 0; y < FRAME_HEIGHT; y++) begin
            px = c.start_x;
            for (x = 0; x < FRAME_WIDTH; x++) begin
                n = escape_count(px, py, c);
                if (n == c.max_iter) n_sat++;
                bytes[nb]   = n[15:8];
                bytes[nb+1] = n[7:0];
                bytes[nb+2] = n[7:0];
                nb          = nb + 3;
                if (x == FRAME_WIDTH - 1) word_last[(nb - 1) / 4] = 1'b1;
                px = px + c.step;
            end
            py = py - c.step;
        end
        for (w = 0; w < WORDS_PER_FRAME; w++) begin
            exp_q.push_back({bytes[4*w+3], bytes[4*w+2], bytes[4*w+1], bytes[4*w],
                             word_last[w], 1'(w == 0)});
        end
    endtask

    task automatic hold_reset(input int cycles);
        repeat (cycles) begin
            @(negedge out_stream_aclk);
            assert (!tvalid) else stop_on_error("tvalid was high while axi_resetn was low");
        end
        axi_resetn = 1'b1;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge out_stream_aclk);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Sink, comparison and watchdog
    ////////////////////////////////////////////////////////////////////
    always @(negedge out_stream_aclk) begin
        if (random_ready) begin
            draw_bits(3, ready_bits);
            tready = (ready_bits == 7);  // mostly stalled so the FIFO fills
        end else begin
            tready = 1'b1;
        end
        assert (DUT.u_assertions.fail_count == 0)
            else stop_on_error("A stream protocol assertion failed");
    end

    always @(posedge out_stream_aclk) begin
        if (DUT.fifo_full) full_cycles++;
        if (axi_resetn && tvalid && tready) begin
            seen_cnt++;
            if (exp_q.size() != 0) begin
                got_beat  = {tdata, tlast, tuser};
                want_beat = exp_q.pop_front();
                assert (got_beat == want_beat)
                    else stop_on_error($sformatf(
                        "MISMATCH at %0t: word %0d got %h last %b user %b, want %h %b %b",
                        $time, checked_cnt, got_beat.data, got_beat.last, got_beat.user,
                        want_beat.data, want_beat.last, want_beat.user));
                checked_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Timeout: the expected stream words did not all arrive");
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        axi_resetn = 1'b0;
        tready     = 1'b1;
        // Q8.24, x from -2.0, y from 1.125, pitch 3/64
        mandel_cfg = '{start_x: coord_t'(-33554432), start_y: coord_t'(18874368),
                       step: coord_t'(786432), max_iter: iter_t'(32), julia: 1'b0,
                       cx: coord_t'(0), cy: coord_t'(0)};
        // c = -0.8 + 0.156i, x from -1.5
        julia_cfg  = '{start_x: coord_t'(-25165824), start_y: coord_t'(18874368),
                       step: coord_t'(786432), max_iter: iter_t'(MAX_ITER_BOUND),
                       julia: 1'b1, cx: coord_t'(-13421773), cy: coord_t'(2617246)};
        cfg = mandel_cfg;
        draw_bits(4, reset_len);
        draw_bits(8, words_before_reset);

        // One Mandelbrot frame, sink always ready
        push_frame(mandel_cfg, saturated);
        assert (saturated > 0 && saturated < PIXELS)
            else stop_on_error("Reference frame has no mix of saturated and escaped pixels");
        hold_reset(5);
        wait_drained();

        // Two frames under back-pressure, Julia settings applied mid frame one
        @(posedge out_stream_aclk);
        random_ready = 1'b1;
        @(negedge out_stream_aclk);
        axi_resetn = 1'b0;
        push_frame(mandel_cfg, saturated);
        push_frame(julia_cfg, saturated);
        full_mark    = full_cycles;
        hold_reset(5);
        while (checked_cnt < WORDS_PER_FRAME + WORDS_PER_FRAME / 2) begin
            @(negedge out_stream_aclk);
        end
        cfg = julia_cfg;
        wait_drained();
        assert (full_cycles > full_mark)
            else stop_on_error("The pixel FIFO never filled under back-pressure");

        // Reset in the middle of the next frame, then a fresh frame
        seen_mark = seen_cnt;
        while (seen_cnt < seen_mark + 64 + words_before_reset) @(negedge out_stream_aclk);
        axi_resetn = 1'b0;
        cfg        = mandel_cfg;
        push_frame(mandel_cfg, saturated);
        hold_reset(2 + reset_len);
        wait_drained();

        if (DUT.u_assertions.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_on_error("A stream protocol assertion failed");
        end
    end

endmodule

//--- tb/pixel_generator_assertions.sv
// Stream protocol checks for the pixel generator
// Bound into pixel_generator on its AXI-Stream outputs

`timescale 1ns/100ps

module pixel_generator_assertions (
    input logic        out_stream_aclk,
    input logic        axi_resetn,
    input logic [31:0] tdata_i,
    input logic [3:0]  tkeep_i,
    input logic        tlast_i,
    input logic        tvalid_i,
    input logic        tuser_i,
    input logic        tready_i
);

    int unsigned fail_count = 0;

    // Synchronous reset clears tvalid one edge later
    reset_quiet: assert property (@(posedge out_stream_aclk) !axi_resetn |=> !tvalid_i)
        else begin
            $error("tvalid high while axi_resetn is asserted");
            fail_count++;
        end

    payload_stable: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        (tvalid_i && !tready_i) |=> $stable({tdata_i, tlast_i, tuser_i}))
        else begin
            $error("tdata, tlast or tuser changed while the word was stalled");
            fail_count++;
        end

    valid_held: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        (tvalid_i && !tready_i) |=> tvalid_i)
        else begin
            $error("tvalid dropped before the word was accepted");
            fail_count++;
        end

    keep_full: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        tvalid_i |-> (tkeep_i == 4'hF))
        else begin
            $error("tkeep not all ones on a valid word");
            fail_count++;
        end

endmodule

bind pixel_generator pixel_generator_assertions u_assertions (
    .out_stream_aclk (out_stream_aclk),
    .axi_resetn      (axi_resetn),
    .tdata_i         (out_stream_tdata_o),
    .tkeep_i         (out_stream_tkeep_o),
    .tlast_i         (out_stream_tlast_o),
    .tvalid_i        (out_stream_tvalid_o),
    .tuser_i         (out_stream_tuser_o),
    .tready_i        (out_stream_tready_i)
);

//--- hdl/pixel_generator.sv
// Fractal pixel generator top level
// Scanner and core feed a pixel FIFO which the stream packer drains

`timescale 1ns/100ps

module pixel_generator (
    input  logic                       out_stream_aclk,
    input  logic                       axi_resetn,
    input  fractal_pkg::fractal_cfg_t  cfg_i,
    output logic [31:0]                out_stream_tdata_o,
    output logic [3:0]                 out_stream_tkeep_o,
    output logic                       out_stream_tlast_o,
    output logic                       out_stream_tvalid_o,
    output logic                       out_stream_tuser_o,
    input  logic                       out_stream_tready_i
);

    import fractal_pkg::*;

    fractal_cfg_t  frame_cfg;
    pixel_job_t    job;
    pixel_result_t core_result, fifo_head;
    logic          core_start, core_busy, core_done;
    logic          fifo_full, fifo_empty, fifo_pop;

    pixel_scan u_scan (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .cfg_i           (cfg_i),
        .fifo_full_i     (fifo_full),
        .core_busy_i     (core_busy),
        .start_o         (core_start),
        .job_o           (job),
        .cfg_o           (frame_cfg)
    );

    escape_core u_core (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .start_i         (core_start),
        .job_i           (job),
        .cfg_i           (frame_cfg),
        .busy_o          (core_busy),
        .done_o          (core_done),
        .result_o        (core_result)
    );

    pixel_fifo u_fifo (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .wr_i            (core_done),     // one pixel in flight, always room
        .wr_data_i       (core_result),
        .rd_i            (fifo_pop),
        .rd_data_o       (fifo_head),
        .full_o          (fifo_full),
        .empty_o         (fifo_empty)
    );

    stream_packer u_packer (
        .out_stream_aclk     (out_stream_aclk),
        .axi_resetn          (axi_resetn),
        .pixel_i             (fifo_head),
        .empty_i             (fifo_empty),
        .pop_o               (fifo_pop),
        .out_stream_tdata_o  (out_stream_tdata_o),
        .out_stream_tkeep_o  (out_stream_tkeep_o),
        .out_stream_tlast_o  (out_stream_tlast_o),
        .out_stream_tvalid_o (out_stream_tvalid_o),
        .out_stream_tuser_o  (out_stream_tuser_o),
        .out_stream_tready_i (out_stream_tready_i)
    );

endmodule

//--- hdl/stream_packer.sv
// Colour mapping and stream packing
// Four 24-bit pixels go out as three 32-bit AXI-Stream words

`timescale 1ns/100ps

module stream_packer (
    input  logic                        out_stream_aclk,
    input  logic                        axi_resetn,
    input  fractal_pkg::pixel_result_t  pixel_i,
    input  logic                        empty_i,
    output logic                        pop_o,
    output logic [31:0]                 out_stream_tdata_o,
    output logic [3:0]                  out_stream_tkeep_o,
    output logic                        out_stream_tlast_o,
    output logic                        out_stream_tvalid_o,
    output logic                        out_stream_tuser_o,
    input  logic                        out_stream_tready_i
);

    import fractal_pkg::*;

    // Blue sits in the low byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    rgb_t                    pix;
    logic [PIXEL_BITS-1:0]   pix_bits;
    logic [PIXEL_BITS-1:0]   hold;       // bytes waiting for the next word
    logic [1:0]              phase;      // pixel index within a group of four
    logic                    sof_hold, eol_hold;
    logic [STREAM_WIDTH-1:0] word_d, tdata_q;
    logic                    last_d;
    logic                    tvalid_q, tlast_q, tuser_q;

    assign pix.red   = pixel_i.iter[7:0];
    assign pix.green = pixel_i.iter[7:0];
    assign pix.blue  = pixel_i.iter[15:8];
    assign pix_bits  = pix;

    // Pop only while the output register is free or being emptied
    assign pop_o = !empty_i && (!tvalid_q || out_stream_tready_i);

    always_comb begin
        case (phase)
            2'd1:    word_d = {pix_bits[7:0], hold[23:0]};
            2'd2:    word_d = {pix_bits[15:0], hold[15:0]};
            2'd3:    word_d = {pix_bits[23:0], hold[7:0]};
            default: word_d = '0;    // first pixel of a group, no word yet
        endcase
        // Last word of a group also completes the fourth pixel
        last_d = eol_hold | ((phase == 2'd3) & pixel_i.eol);
    end

    ////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            phase    <= '0;
            tvalid_q <= 1'b0;
        end else begin
            if (tvalid_q && out_stream_tready_i) tvalid_q <= 1'b0;
            if (pop_o) begin
                phase <= phase + 1'b1;
                if (phase != 2'd0) tvalid_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Payload
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge out_stream_aclk) begin
        if (pop_o) begin
            eol_hold <= pixel_i.eol;
            case (phase)
                2'd0: begin
                    hold     <= pix_bits;
                    sof_hold <= pixel_i.sof;
                end
                2'd1: hold[15:0] <= pix_bits[23:8];
                2'd2: hold[7:0]  <= pix_bits[23:16];
                default: ;
            endcase
            if (phase != 2'd0) begin
                tdata_q <= word_d;
                tlast_q <= last_d;
                tuser_q <= (phase == 2'd1) & sof_hold;  // only the group's first word
            end
        end
    end

    assign out_stream_tdata_o  = tdata_q;
    assign out_stream_tkeep_o  = '1;
    assign out_stream_tlast_o  = tlast_q;
    assign out_stream_tvalid_o = tvalid_q;
    assign out_stream_tuser_o  = tuser_q;

endmodule

//--- hdl/pixel_fifo.sv
// Finished pixel buffer
// Circular FIFO between the iteration core and the stream packer

`timescale 1ns/100ps

module pixel_fifo (
    input  logic                        out_stream_aclk,
    input  logic                        axi_resetn,
    input  logic                        wr_i,
    input  fractal_pkg::pixel_result_t  wr_data_i,
    input  logic                        rd_i,
    output fractal_pkg::pixel_result_t  rd_data_o,
    output logic                        full_o,
    output logic                        empty_o
);

    import fractal_pkg::*;

    pixel_result_t mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic                            do_rd;

    assign do_rd = rd_i && !empty_o;

    always_ff @(posedge out_stream_aclk) begin
        if (wr_i) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_i, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rd_data_o = mem[rd_ptr];  // head entry, valid while not empty
    assign full_o    = (count == FIFO_DEPTH);
    assign empty_o   = (count == '0);

endmodule

//--- hdl/escape_core.sv
// Escape-time iteration core
// Runs z = z^2 + c in Q8.24, one step per clock, Mandelbrot or Julia mode

`timescale 1ns/100ps

module escape_core (
    input  logic                       out_stream_aclk,
    input  logic                       axi_resetn,
    input  logic                       start_i,
    input  fractal_pkg::pixel_job_t    job_i,
    input  fractal_pkg::fractal_cfg_t  cfg_i,
    output logic                       busy_o,
    output logic                       done_o,
    output fractal_pkg::pixel_result_t result_o
);

    import fractal_pkg::*;

    coord_t        zx, zy, cx, cy;
    iter_t         iter_cnt, max_iter_q;
    pixel_result_t result_q;
    logic          running, done_q;

    logic signed [2*COORD_WIDTH-1:0] prod_xx, prod_yy, prod_xy;
    coord_t sq_x, sq_y, xy, mag;
    logic   escaped, finish;

    ////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////
    assign prod_xx = zx * zx;
    assign prod_yy = zy * zy;
    assign prod_xy = zx * zy;

    assign sq_x = coord_t'(prod_xx >>> FRACTIONAL_BITS);
    assign sq_y = coord_t'(prod_yy >>> FRACTIONAL_BITS);
    assign xy   = coord_t'(prod_xy >>> FRACTIONAL_BITS);
    assign mag  = sq_x + sq_y;  // wraps at 32 bits

    assign escaped = (mag > ESCAPE_LIMIT);
    assign finish  = escaped || (iter_cnt == max_iter_q);

    ////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            running <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                running <= 1'b1;
            end else if (running && finish) begin
                running <= 1'b0;
                done_q  <= 1'b1;
            end
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (start_i) begin
            iter_cnt     <= '0;
            max_iter_q   <= cfg_i.max_iter;
            result_q.sof <= job_i.sof;
            result_q.eol <= job_i.eol;
            if (cfg_i.julia) begin
                zx <= job_i.zx;
                zy <= job_i.zy;
                cx <= cfg_i.cx;
                cy <= cfg_i.cy;
            end else begin
                zx <= '0;
                zy <= '0;
                cx <= job_i.zx;
                cy <= job_i.zy;
            end
        end else if (running) begin
            if (finish) begin
                result_q.iter <= iter_cnt;
            end else begin
                zx       <= sq_x - sq_y + cx;
                zy       <= xy + xy + cy;
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    // Busy covers the done cycle so the scanner sees the FIFO after the write
    assign busy_o   = running | done_q;
    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

//--- hdl/pixel_scan.sv
// Raster walker for the fractal generator
// Steps the complex coordinate and hands one pixel at a time to the core

`timescale 1ns/100ps

module pixel_scan (
    input  logic                       out_stream_aclk,
    input  logic                       axi_resetn,
    input  fractal_pkg::fractal_cfg_t  cfg_i,
    input  logic                       fifo_full_i,
    input  logic                       core_busy_i,
    output logic                       start_o,
    output fractal_pkg::pixel_job_t    job_o,
    output fractal_pkg::fractal_cfg_t  cfg_o
);

    import fractal_pkg::*;

    logic [X_WIDTH-1:0] x_cnt;
    logic [Y_WIDTH-1:0] y_cnt;
    coord_t             cur_x, cur_y;  // coordinate of the next pixel
    coord_t             px, py;
    fractal_cfg_t       cfg_q, cfg_now;
    pixel_job_t         job_q;
    logic               start_q;
    logic               issue;
    logic               frame_start, last_x, last_y;

    assign frame_start = (x_cnt == '0) && (y_cnt == '0);
    assign last_x      = (x_cnt == X_WIDTH'(FRAME_WIDTH - 1));
    assign last_y      = (y_cnt == Y_WIDTH'(FRAME_HEIGHT - 1));

    // New settings only at the top left pixel
    assign cfg_now = frame_start ? cfg_i : cfg_q;
    assign px      = frame_start ? cfg_i.start_x : cur_x;
    assign py      = frame_start ? cfg_i.start_y : cur_y;

    // Core idle, no start in flight, room in the FIFO
    assign issue = !core_busy_i && !start_q && !fifo_full_i;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            x_cnt   <= '0;
            y_cnt   <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= issue;
            if (issue) begin
                if (last_x) begin
                    x_cnt <= '0;
                    y_cnt <= last_y ? '0 : y_cnt + 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (issue) begin
            cfg_q <= cfg_now;
            job_q <= '{zx: px, zy: py, sof: frame_start, eol: last_x};
            if (last_x) begin
                cur_x <= cfg_now.start_x;
                cur_y <= py - cfg_now.step;  // y runs downwards
            end else begin
                cur_x <= px + cfg_now.step;
                cur_y <= py;
            end
        end
    end

    assign start_o = start_q;
    assign job_o   = job_q;
    assign cfg_o   = cfg_q;

endmodule

//--- hdl/fractal_pkg.sv
// Fractal pixel generator shared definitions
// Q8.24 number format, raster size and the structs passed between blocks

package fractal_pkg;

    ////////////////////////////////////////////////////////////////////
    // Fixed point and iteration
    ////////////////////////////////////////////////////////////////////
    localparam int INTEGER_BITS    = 8;
    localparam int FRACTIONAL_BITS = 24;
    localparam int COORD_WIDTH     = INTEGER_BITS + FRACTIONAL_BITS;
    localparam int ITER_WIDTH      = 16;

    typedef logic signed [COORD_WIDTH-1:0] coord_t;
    typedef logic [ITER_WIDTH-1:0]         iter_t;

    localparam coord_t ESCAPE_LIMIT = coord_t'(4 << FRACTIONAL_BITS); // 4.0

    ////////////////////////////////////////////////////////////////////
    // Raster and stream
    ////////////////////////////////////////////////////////////////////
    localparam int FRAME_WIDTH  = 64;
    localparam int FRAME_HEIGHT = 48;
    localparam int X_WIDTH      = $clog2(FRAME_WIDTH);
    localparam int Y_WIDTH      = $clog2(FRAME_HEIGHT);

    localparam int PIXEL_BITS   = 24;
    localparam int STREAM_WIDTH = 32;
    localparam int FIFO_DEPTH   = 4;

    // Sampled at every frame start
    typedef struct packed {
        coord_t start_x;
        coord_t start_y;
        coord_t step;
        iter_t  max_iter;
        logic   julia;      // 0 Mandelbrot, 1 Julia
        coord_t cx;
        coord_t cy;
    } fractal_cfg_t;

    typedef struct packed {
        coord_t zx;
        coord_t zy;
        logic   sof;
        logic   eol;
    } pixel_job_t;

    typedef struct packed {
        iter_t iter;
        logic  sof;
        logic  eol;
    } pixel_result_t;

endpackage
